/* logic/fetch_settings.svh */
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// Instruction and address width
`define XLEN 32

// Instruction buffer entries as a power of two
`define IBUF_DEPTH 16

// RISC-V major opcodes seen by the predecoder
`define OPC_BRANCH 7'b1100011
`define OPC_JAL 7'b1101111

`endif

/* logic/frontend_pkg.sv */
`default_nettype none

`include "fetch_settings.svh"

package frontend_pkg;

    // Index width into the instruction buffer
    localparam int IBUF_PTR_W = $clog2(`IBUF_DEPTH);

    // One fetched instruction word
    typedef logic [`XLEN-1:0] inst_t;

    // Program counter or predicted branch target
    typedef logic [`XLEN-1:0] addr_t;

    // Buffer head and tail pointers
    typedef logic [IBUF_PTR_W-1:0] ibuf_ptr_t;

    // Occupancy is one bit wider so a full buffer fits
    typedef logic [IBUF_PTR_W:0] ibuf_cnt_t;

endpackage

`default_nettype wire

/* logic/branch_predecode.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fetch_settings.svh"

module branch_predecode (
    input  frontend_pkg::addr_t pc_i,
    input  frontend_pkg::inst_t inst_i,
    output logic                is_branch_o,
    output logic                taken_o,
    output frontend_pkg::addr_t target_o
);
    import frontend_pkg::*;

    logic [6:0]  opcode;
    logic        is_cond;
    logic        is_jal;
    logic [12:0] imm_b;
    logic [20:0] imm_j;
    addr_t       offset;

    assign opcode  = inst_i[6:0];
    assign is_cond = (opcode == `OPC_BRANCH);
    assign is_jal  = (opcode == `OPC_JAL);

    // B-type immediate with bit 0 always zero
    assign imm_b = {inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

    // J-type immediate
    assign imm_j = {inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    always_comb begin
        if (is_jal) begin
            offset = {{(`XLEN-21){imm_j[20]}}, imm_j};
        end else begin
            offset = {{(`XLEN-13){imm_b[12]}}, imm_b};
        end
    end

    assign is_branch_o = is_cond || is_jal;

    // Jumps always taken and conditional branches only when backward
    assign taken_o = is_jal || (is_cond && imm_b[12]);

    always_comb begin
        if (is_branch_o) begin
            target_o = pc_i + offset;
        end else begin
            target_o = '0;
        end
    end

endmodule

`default_nettype wire

/* logic/inst_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fetch_settings.svh"

module inst_buffer #(
    parameter int DEPTH = `IBUF_DEPTH
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                flush_i,

    input  logic                enq_valid_i,
    input  frontend_pkg::addr_t enq_pc_i,
    input  frontend_pkg::inst_t enq_inst_i,
    input  logic                enq_is_branch_i,
    input  logic                enq_taken_i,
    input  frontend_pkg::addr_t enq_target_i,
    output logic                enq_ready_o,

    input  logic                issue1_en_i,
    input  logic                issue2_en_i,

    output logic                slot0_valid_o,
    output frontend_pkg::addr_t slot0_pc_o,
    output frontend_pkg::inst_t slot0_inst_o,
    output logic                slot0_taken_o,
    output frontend_pkg::addr_t slot0_target_o,

    output logic                slot1_valid_o,
    output frontend_pkg::addr_t slot1_pc_o,
    output frontend_pkg::inst_t slot1_inst_o,
    output logic                slot1_taken_o,
    output frontend_pkg::addr_t slot1_target_o
);
    import frontend_pkg::*;

    localparam ibuf_cnt_t FULL_CNT = ibuf_cnt_t'(DEPTH);

    // Entry storage
    addr_t pc_mem     [DEPTH];
    inst_t inst_mem   [DEPTH];
    logic  br_mem     [DEPTH];
    logic  taken_mem  [DEPTH];
    addr_t target_mem [DEPTH];

    ibuf_ptr_t head_q;
    ibuf_ptr_t tail_q;
    ibuf_ptr_t head_nxt;
    ibuf_cnt_t count_q;
    logic      shadow_q;

    logic       accept;
    logic       do_write;
    logic [1:0] n_req;
    logic [1:0] n_deq;

    function automatic ibuf_ptr_t ptr_add(input ibuf_ptr_t p, input logic [1:0] n);
        ptr_add = (p + ibuf_ptr_t'(n)) & ibuf_ptr_t'(DEPTH - 1);
    endfunction

    assign enq_ready_o = (count_q != FULL_CNT);
    assign accept      = enq_valid_i && enq_ready_o && !flush_i;

    // Entry right after a predicted-taken branch is wrong path
    assign do_write = accept && !shadow_q;

    assign n_req    = {1'b0, issue1_en_i} + {1'b0, issue2_en_i};
    assign head_nxt = ptr_add(head_q, 2'd1);

    // Only entries present at the start of the cycle can leave
    always_comb begin
        if (count_q < ibuf_cnt_t'(n_req)) begin
            n_deq = count_q[1:0];
        end else begin
            n_deq = n_req;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            head_q   <= '0;
            tail_q   <= '0;
            count_q  <= '0;
            shadow_q <= 1'b0;
        end else begin
            if (do_write) begin
                tail_q <= ptr_add(tail_q, 2'd1);
            end
            // A dropped entry never re-arms the shadow
            if (accept) begin
                shadow_q <= !shadow_q && enq_taken_i;
            end
            head_q  <= ptr_add(head_q, n_deq);
            count_q <= count_q + ibuf_cnt_t'(do_write) - ibuf_cnt_t'(n_deq);
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            pc_mem[tail_q]     <= enq_pc_i;
            inst_mem[tail_q]   <= enq_inst_i;
            br_mem[tail_q]     <= enq_is_branch_i;
            taken_mem[tail_q]  <= enq_taken_i;
            target_mem[tail_q] <= enq_target_i;
        end
    end

    // Slots are shown for one cycle only
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            slot0_valid_o <= 1'b0;
            slot1_valid_o <= 1'b0;
        end else begin
            slot0_valid_o <= (n_deq != 2'd0);
            slot1_valid_o <= (n_deq == 2'd2);
        end
    end

    always_ff @(posedge clk) begin
        if (n_deq != 2'd0) begin
            slot0_pc_o     <= pc_mem[head_q];
            slot0_inst_o   <= inst_mem[head_q];
            slot0_taken_o  <= br_mem[head_q] && taken_mem[head_q];
            slot0_target_o <= target_mem[head_q];
        end
        if (n_deq == 2'd2) begin
            slot1_pc_o     <= pc_mem[head_nxt];
            slot1_inst_o   <= inst_mem[head_nxt];
            slot1_taken_o  <= br_mem[head_nxt] && taken_mem[head_nxt];
            slot1_target_o <= target_mem[head_nxt];
        end
    end

endmodule

`default_nettype wire

/* logic/dual_issue_fetch.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fetch_settings.svh"

module dual_issue_fetch (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                flush_i,

    input  logic                fetch_valid_i,
    input  frontend_pkg::addr_t fetch_pc_i,
    input  frontend_pkg::inst_t fetch_inst_i,
    output logic                fetch_ready_o,

    input  logic                issue1_en_i,
    input  logic                issue2_en_i,

    output logic                slot0_valid_o,
    output frontend_pkg::addr_t slot0_pc_o,
    output frontend_pkg::inst_t slot0_inst_o,
    output logic                slot0_taken_o,
    output frontend_pkg::addr_t slot0_target_o,

    output logic                slot1_valid_o,
    output frontend_pkg::addr_t slot1_pc_o,
    output frontend_pkg::inst_t slot1_inst_o,
    output logic                slot1_taken_o,
    output frontend_pkg::addr_t slot1_target_o
);
    import frontend_pkg::*;

    // Predecode results for the instruction on offer
    logic  pd_is_branch;
    logic  pd_taken;
    addr_t pd_target;

    branch_predecode u_predecode (
        .pc_i        (fetch_pc_i),
        .inst_i      (fetch_inst_i),
        .is_branch_o (pd_is_branch),
        .taken_o     (pd_taken),
        .target_o    (pd_target)
    );

    inst_buffer #(
        .DEPTH (`IBUF_DEPTH)
    ) u_ibuf (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .flush_i         (flush_i),
        .enq_valid_i     (fetch_valid_i),
        .enq_pc_i        (fetch_pc_i),
        .enq_inst_i      (fetch_inst_i),
        .enq_is_branch_i (pd_is_branch),
        .enq_taken_i     (pd_taken),
        .enq_target_i    (pd_target),
        .enq_ready_o     (fetch_ready_o),
        .issue1_en_i     (issue1_en_i),
        .issue2_en_i     (issue2_en_i),
        .slot0_valid_o   (slot0_valid_o),
        .slot0_pc_o      (slot0_pc_o),
        .slot0_inst_o    (slot0_inst_o),
        .slot0_taken_o   (slot0_taken_o),
        .slot0_target_o  (slot0_target_o),
        .slot1_valid_o   (slot1_valid_o),
        .slot1_pc_o      (slot1_pc_o),
        .slot1_inst_o    (slot1_inst_o),
        .slot1_taken_o   (slot1_taken_o),
        .slot1_target_o  (slot1_target_o)
    );

endmodule

`default_nettype wire

/* dv/fetch_chk.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fetch_settings.svh"

module fetch_chk #(
    parameter int DEPTH = `IBUF_DEPTH
) (
    input logic                    clk,
    input logic                    rst_n_i,
    input logic                    flush_i,
    input frontend_pkg::ibuf_cnt_t count_i,
    input logic                    slot0_valid_i,
    input logic                    slot1_valid_i
);

    // Count of failed assertions
    int fail_count = 0;

    count_in_range: assert property (@(posedge clk) disable iff (!rst_n_i)
        int'(count_i) <= DEPTH)
        else begin
            fail_count++;
            $error("buffer occupancy %0d exceeds depth %0d", count_i, DEPTH);
        end

    slot1_needs_slot0: assert property (@(posedge clk) disable iff (!rst_n_i)
        slot1_valid_i |-> slot0_valid_i)
        else begin
            fail_count++;
            $error("slot1 valid while slot0 is not");
        end

    // Flush kills anything that would be presented next
    slots_clear_after_flush: assert property (@(posedge clk) disable iff (!rst_n_i)
        flush_i |=> (!slot0_valid_i && !slot1_valid_i))
        else begin
            fail_count++;
            $error("issue slot valid in the cycle after a flush");
        end

endmodule

bind inst_buffer fetch_chk #(
    .DEPTH (DEPTH)
) u_chk (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .count_i       (count_q),
    .slot0_valid_i (slot0_valid_o),
    .slot1_valid_i (slot1_valid_o)
);

`default_nettype wire

/* dv/fetch_scoreboard.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fetch_settings.svh"

module fetch_scoreboard (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                fetch_valid_i,
    input  frontend_pkg::addr_t fetch_pc_i,
    input  frontend_pkg::inst_t fetch_inst_i,
    input  logic                fetch_ready_i,
    input  logic                issue1_en_i,
    input  logic                issue2_en_i,
    input  logic                slot0_valid_i,
    input  frontend_pkg::addr_t slot0_pc_i,
    input  frontend_pkg::inst_t slot0_inst_i,
    input  logic                slot0_taken_i,
    input  frontend_pkg::addr_t slot0_target_i,
    input  logic                slot1_valid_i,
    input  frontend_pkg::addr_t slot1_pc_i,
    input  frontend_pkg::inst_t slot1_inst_i,
    input  logic                slot1_taken_i,
    input  frontend_pkg::addr_t slot1_target_i,
    output int                  error_count_o,
    output int                  check_count_o,
    output int                  drop_count_o
);
    import frontend_pkg::*;

    // Model of the buffer contents with the oldest first
    addr_t pc_q   [$];
    inst_t inst_q [$];

    // Entries expected on the slots after the last edge
    addr_t exp_pc   [2];
    inst_t exp_inst [2];
    int    exp_n  = 0;
    logic  shadow = 1'b0;

    int errors = 0;
    int checks = 0;
    int drops  = 0;

    assign error_count_o = errors;
    assign check_count_o = checks;
    assign drop_count_o  = drops;

    function automatic void predict(input addr_t pc, input inst_t inst,
                                    output logic taken, output addr_t target);
        int off;
        taken  = 1'b0;
        target = '0;
        if (inst[6:0] == `OPC_JAL) begin
            off = (int'(inst[19:12]) << 12) + (int'(inst[20]) << 11) + (int'(inst[30:21]) << 1);
            if (inst[31]) begin
                off = off - (1 << 20);
            end
            taken  = 1'b1;
            target = pc + addr_t'(off);
        end else if (inst[6:0] == `OPC_BRANCH) begin
            off = (int'(inst[7]) << 11) + (int'(inst[30:25]) << 5) + (int'(inst[11:8]) << 1);
            if (inst[31]) begin
                off = off - (1 << 12);
            end
            // Backward branches taken and forward ones not
            taken  = (off < 0);
            target = pc + addr_t'(off);
        end
    endfunction

    task automatic flag_error(input string msg);
        errors++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    task automatic check_slot(input int idx, input logic valid, input addr_t pc,
                              input inst_t inst, input logic taken, input addr_t target);
        logic  exp_valid;
        logic  exp_taken;
        addr_t exp_target;
        exp_valid = (idx < exp_n);
        checks++;
        if (valid !== exp_valid) begin
            flag_error($sformatf("slot%0d valid is %b, expected %b", idx, valid, exp_valid));
        end else if (exp_valid) begin
            predict(exp_pc[idx], exp_inst[idx], exp_taken, exp_target);
            if (pc !== exp_pc[idx] || inst !== exp_inst[idx]) begin
                flag_error($sformatf("slot%0d carries pc %h inst %h, expected pc %h inst %h",
                                     idx, pc, inst, exp_pc[idx], exp_inst[idx]));
            end
            if (taken !== exp_taken || target !== exp_target) begin
                flag_error($sformatf("slot%0d prediction %b/%h, expected %b/%h",
                                     idx, taken, target, exp_taken, exp_target));
            end
        end
    endtask

    always @(posedge clk) begin
        logic  acc_taken;
        addr_t acc_target;
        int    n_req;
        int    n_deq;
        if (rst_n_i) begin
            check_slot(0, slot0_valid_i, slot0_pc_i, slot0_inst_i, slot0_taken_i, slot0_target_i);
            check_slot(1, slot1_valid_i, slot1_pc_i, slot1_inst_i, slot1_taken_i, slot1_target_i);
            checks++;
            if (fetch_ready_i !== (pc_q.size() != `IBUF_DEPTH)) begin
                flag_error($sformatf("fetch_ready_o is %b with %0d entries held",
                                     fetch_ready_i, pc_q.size()));
            end
        end
        if (!rst_n_i || flush_i) begin
            pc_q.delete();
            inst_q.delete();
            shadow = 1'b0;
            exp_n  = 0;
        end else begin
            // Occupancy before this edge's write limits the dequeue
            n_req = int'(issue1_en_i) + int'(issue2_en_i);
            n_deq = (n_req < pc_q.size()) ? n_req : pc_q.size();
            exp_n = n_deq;
            for (int i = 0; i < n_deq; i++) begin
                exp_pc[i]   = pc_q.pop_front();
                exp_inst[i] = inst_q.pop_front();
            end
            if (fetch_valid_i && fetch_ready_i) begin
                if (shadow) begin
                    shadow = 1'b0;
                    drops++;
                end else begin
                    predict(fetch_pc_i, fetch_inst_i, acc_taken, acc_target);
                    pc_q.push_back(fetch_pc_i);
                    inst_q.push_back(fetch_inst_i);
                    shadow = acc_taken;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* dv/tb_dual_issue_fetch.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fetch_settings.svh"

module tb_dual_issue_fetch;
    import frontend_pkg::*;

    localparam int RESET_CYCLES   = 5;
    localparam int STIM_CYCLES    = 2000;
    localparam int DRAIN_CYCLES   = 8;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + STIM_CYCLES + DRAIN_CYCLES + 200;
    localparam int unsigned SEED  = 32'h3d5f;

    logic  clk = 1'b0;
    logic  rst_n_i;
    logic  flush_i;
    logic  fetch_valid_i;
    addr_t fetch_pc_i;
    inst_t fetch_inst_i;
    logic  fetch_ready_o;
    logic  issue1_en_i;
    logic  issue2_en_i;
    logic  slot0_valid_o;
    addr_t slot0_pc_o;
    inst_t slot0_inst_o;
    logic  slot0_taken_o;
    addr_t slot0_target_o;
    logic  slot1_valid_o;
    addr_t slot1_pc_o;
    inst_t slot1_inst_o;
    logic  slot1_taken_o;
    addr_t slot1_target_o;

    int    error_count;
    int    check_count;
    int    drop_count;
    int    assert_fails;
    int    cycle_count = 0;
    int    stim_cycle;
    int unsigned seed_ret;
    addr_t next_pc;
    // Offer refused by back-pressure at the last edge
    logic  offer_open = 1'b0;

    always #2 clk = ~clk;

    dual_issue_fetch dut0 (.*);

    fetch_scoreboard u_scoreboard (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .fetch_valid_i  (fetch_valid_i),
        .fetch_pc_i     (fetch_pc_i),
        .fetch_inst_i   (fetch_inst_i),
        .fetch_ready_i  (fetch_ready_o),
        .issue1_en_i    (issue1_en_i),
        .issue2_en_i    (issue2_en_i),
        .slot0_valid_i  (slot0_valid_o),
        .slot0_pc_i     (slot0_pc_o),
        .slot0_inst_i   (slot0_inst_o),
        .slot0_taken_i  (slot0_taken_o),
        .slot0_target_i (slot0_target_o),
        .slot1_valid_i  (slot1_valid_o),
        .slot1_pc_i     (slot1_pc_o),
        .slot1_inst_i   (slot1_inst_o),
        .slot1_taken_i  (slot1_taken_o),
        .slot1_target_i (slot1_target_o),
        .error_count_o  (error_count),
        .check_count_o  (check_count),
        .drop_count_o   (drop_count)
    );

    assign assert_fails = dut0.u_ibuf.u_chk.fail_count;

    always @(posedge clk) begin
        offer_open <= rst_n_i && fetch_valid_i && !fetch_ready_o && !flush_i;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic make_offer();
        int unsigned kind;
        logic [24:0] fields;
        logic [6:0]  opcode;
        kind   = $urandom_range(0, 9);
        fields = 25'($urandom);
        case (kind)
            0, 1, 2: opcode = `OPC_BRANCH;
            3:       opcode = `OPC_JAL;
            4:       opcode = 7'b0000011;
            5:       opcode = 7'b0100011;
            6:       opcode = 7'b0110111;
            7:       opcode = 7'b0110011;
            default: opcode = 7'b0010011;
        endcase
        // Occasional redirect to a fresh region
        if ($urandom_range(0, 49) == 0) begin
            next_pc = $urandom & 32'hffff_fffc;
        end
        fetch_valid_i = ($urandom_range(0, 99) < 70);
        fetch_pc_i    = next_pc;
        fetch_inst_i  = {fields, opcode};
        next_pc       = next_pc + 32'd4;
    endtask

    task automatic pick_issue(input int cyc);
        int unsigned pct;
        // Slow phases let the buffer fill up
        case ((cyc / 150) % 3)
            0:       pct = 15;
            1:       pct = 85;
            default: pct = 50;
        endcase
        issue1_en_i = ($urandom_range(0, 99) < pct);
        issue2_en_i = ($urandom_range(0, 99) < pct);
    endtask

    initial begin
        seed_ret      = $urandom(SEED);
        rst_n_i       = 1'b0;
        flush_i       = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_pc_i    = '0;
        fetch_inst_i  = '0;
        issue1_en_i   = 1'b0;
        issue2_en_i   = 1'b0;
        next_pc       = 32'h0000_1000;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n_i = 1'b1;
        for (stim_cycle = 0; stim_cycle < STIM_CYCLES; stim_cycle++) begin
            if (!offer_open) begin
                make_offer();
            end
            pick_issue(stim_cycle);
            flush_i = ($urandom_range(0, 149) == 0);
            @(negedge clk);
        end
        fetch_valid_i = 1'b0;
        flush_i       = 1'b0;
        issue1_en_i   = 1'b1;
        issue2_en_i   = 1'b1;
        repeat (DRAIN_CYCLES) @(negedge clk);
        $display("Summary: %0d checks, %0d mismatches, %0d assertion failures, %0d drops",
                 check_count, error_count, assert_fails, drop_count);
        if (error_count == 0 && assert_fails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dual_issue_fetch.f */
+incdir+logic
logic/frontend_pkg.sv
logic/branch_predecode.sv
logic/inst_buffer.sv
logic/dual_issue_fetch.sv
dv/fetch_chk.sv
dv/fetch_scoreboard.sv
dv/tb_dual_issue_fetch.sv

/* Bender.yml */
package:
  name: dual_issue_fetch

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/frontend_pkg.sv
      - logic/branch_predecode.sv
      - logic/inst_buffer.sv
      - logic/dual_issue_fetch.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - dv/fetch_chk.sv
      - dv/fetch_scoreboard.sv
      - dv/tb_dual_issue_fetch.sv
